// File: aexmBpcu.sv
/* AEXM branch and PC unit
   Fetch PC, X-stage branch resolution and two-slot squash */
`timescale 1ns/1ps
`include "aexm_defs.svh"

module aexmBpcu
  import aexmIsaPkg::*;
(
  input  logic                sysClk_i,
  input  logic                rstN_i,
  input  logic                cpuEnable_i,
  input  logic                isBranch_i,
  input  opcodeE              opc_i,
  input  regIdxT              rd_i,         // Condition field
  input  logic [`AEXM_DW-1:0] opA_i,        // Forwarded rA
  input  logic [`AEXM_DW-1:0] simm_i,
  output logic [`AEXM_DW-1:0] fetchAddr_o,
  output logic                squash_o
);

  localparam logic [`AEXM_DW-1:0] InsnBytes = 4;

  logic [`AEXM_DW-1:0] rPc;   // F
  logic [`AEXM_DW-1:0] rPcD;  // PC of word in D
  logic [`AEXM_DW-1:0] rPcX;  // PC of instruction in X
  logic                rSquash;
  logic                condMet;
  logic                taken;

  always_comb begin
    case (branchCondE'(rd_i[2:0]))
      CondEq:  condMet = (opA_i == '0);
      CondNe:  condMet = (opA_i != '0);
      default: condMet = 1'b0;
    endcase
  end

  assign taken = isBranch_i && ((opc_i == OpcBri) || (opc_i == OpcBcci && condMet));

  // Kills D now and F next slot, also the stale word seen just after reset
  assign squash_o = taken | rSquash;

  always_ff @(posedge sysClk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      rPc     <= `AEXM_RESET_PC;
      rPcD    <= `AEXM_RESET_PC;
      rPcX    <= `AEXM_RESET_PC;
      rSquash <= 1'b1;
    end else if (cpuEnable_i) begin
      rPc     <= taken ? rPcX + simm_i : rPc + InsnBytes;  // Redirect or step
      rPcD    <= rPc;
      rPcX    <= rPcD;
      rSquash <= taken;
    end
  end

  assign fetchAddr_o = rPc;

endmodule

// File: aexmCore.sv
/* AEXM core top level
   Four-stage integer pipeline on instruction and data cache precycle ports */
`timescale 1ns/1ps
`include "aexm_defs.svh"

module aexmCore
  import aexmIsaPkg::*;
  import aexmCtrlPkg::*;
(
  input  logic                sysClk_i,
  input  logic                rstN_i,
  output logic [`AEXM_DW-1:0] icachePrecycleAddr_o,
  output logic                icachePrecycleEnable_o,
  input  logic [`AEXM_DW-1:0] icacheDatai_i,
  input  logic                icacheCacheBusy_i,
  output logic [`AEXM_DW-1:0] dcachePrecycleAddr_o,
  output logic                dcachePrecycleEnable_o,
  output logic                dcachePrecycleWe_o,
  output logic [`AEXM_DW-1:0] dcacheDatao_o,
  input  logic [`AEXM_DW-1:0] dcacheDatai_i,
  input  logic                dcacheCacheBusy_i
);

  logic                cpuEnable, memOp, isBranch, squash;
  opcodeE              opc;
  regIdxT              rd, ra, rb, dRa, dRb, wrReg;
  aluOpE               aluOp;
  srcSelE              srcSel;
  dstSelE              dstSel;
  logic [`AEXM_DW-1:0] simm, regA, regB, regD, wbValue, xResult, rResult;

  aexmEnable u_aexmEnable (
    .sysClk_i(sysClk_i), .rstN_i(rstN_i),
    .icacheBusy_i(icacheCacheBusy_i), .dcacheBusy_i(dcacheCacheBusy_i),
    .memOp_i(memOp), .cpuEnable_o(cpuEnable),
    .icacheEnable_o(icachePrecycleEnable_o), .dcacheEnable_o(dcachePrecycleEnable_o)
  );

  aexmIbuf u_aexmIbuf (
    .sysClk_i(sysClk_i), .rstN_i(rstN_i), .cpuEnable_i(cpuEnable),
    .squash_i(squash), .icacheData_i(icacheDatai_i),
    .opc_o(opc), .rd_o(rd), .ra_o(ra), .rb_o(rb), .simm_o(simm),
    .dRa_o(dRa), .dRb_o(dRb)
  );

  aexmCtrl u_aexmCtrl (
    .sysClk_i(sysClk_i), .rstN_i(rstN_i), .cpuEnable_i(cpuEnable),
    .squash_i(squash), .opc_i(opc), .rd_i(rd),
    .aluOp_o(aluOp), .srcSel_o(srcSel), .dstSel_o(dstSel), .wrReg_o(wrReg),
    .memOp_o(memOp), .storeOp_o(dcachePrecycleWe_o), .isBranch_o(isBranch)
  );

  aexmRegf u_aexmRegf (
    .sysClk_i(sysClk_i), .rstN_i(rstN_i), .cpuEnable_i(cpuEnable),
    .dRa_i(dRa), .dRb_i(dRb), .rd_i(rd), .wrReg_i(wrReg), .dstSel_i(dstSel),
    .result_i(rResult), .loadData_i(dcacheDatai_i),
    .regA_o(regA), .regB_o(regB), .regD_o(regD), .wbValue_o(wbValue)
  );

  aexmXecu u_aexmXecu (
    .sysClk_i(sysClk_i), .rstN_i(rstN_i), .cpuEnable_i(cpuEnable),
    .aluOp_i(aluOp), .srcSel_i(srcSel), .ra_i(ra), .rb_i(rb), .rd_i(rd),
    .simm_i(simm), .regA_i(regA), .regB_i(regB), .regD_i(regD),
    .wrReg_i(wrReg), .wbValue_i(wbValue),
    .result_o(xResult), .rResult_o(rResult),
    .dataAddr_o(dcachePrecycleAddr_o), .storeData_o(dcacheDatao_o)
  );

  // Branch test value comes through the ALU pass path
  aexmBpcu u_aexmBpcu (
    .sysClk_i(sysClk_i), .rstN_i(rstN_i), .cpuEnable_i(cpuEnable),
    .isBranch_i(isBranch), .opc_i(opc), .rd_i(rd), .opA_i(xResult),
    .simm_i(simm), .fetchAddr_o(icachePrecycleAddr_o), .squash_o(squash)
  );

endmodule

// File: aexmCtrl.sv
/* AEXM decoder
   X-stage mux selects and memory flags, W-stage destination pipeline */
`timescale 1ns/1ps

module aexmCtrl
  import aexmIsaPkg::*;
  import aexmCtrlPkg::*;
(
  input  logic   sysClk_i,
  input  logic   rstN_i,
  input  logic   cpuEnable_i,
  input  logic   squash_i,
  input  opcodeE opc_i,
  input  regIdxT rd_i,
  output aluOpE  aluOp_o,
  output srcSelE srcSel_o,
  output dstSelE dstSel_o,     // W stage
  output regIdxT wrReg_o,      // W stage, zero when nothing is written
  output logic   memOp_o,
  output logic   storeOp_o,    // Goes out as the data write enable
  output logic   isBranch_o
);

  dstSelE xDst;  // Writeback source of the X instruction
  dstSelE rDst;
  regIdxT rWrReg;

  always_comb begin
    aluOp_o    = AluPass;  // Unsupported opcodes fall through as nops
    srcSel_o   = SrcReg;
    xDst       = DstNone;
    memOp_o    = 1'b0;
    storeOp_o  = 1'b0;
    isBranch_o = 1'b0;
    case (opc_i)
      OpcAdd:   begin aluOp_o = AluAdd;  xDst = DstAlu; end
      OpcRsub:  begin aluOp_o = AluRsub; xDst = DstAlu; end
      OpcAnd:   begin aluOp_o = AluAnd;  xDst = DstAlu; end
      OpcOr:    begin aluOp_o = AluOr;   xDst = DstAlu; end
      OpcXor:   begin aluOp_o = AluXor;  xDst = DstAlu; end
      OpcAddi:  begin aluOp_o = AluAdd;  srcSel_o = SrcImm; xDst = DstAlu; end
      OpcRsubi: begin aluOp_o = AluRsub; srcSel_o = SrcImm; xDst = DstAlu; end
      OpcAndi:  begin aluOp_o = AluAnd;  srcSel_o = SrcImm; xDst = DstAlu; end
      OpcOri:   begin aluOp_o = AluOr;   srcSel_o = SrcImm; xDst = DstAlu; end
      OpcXori:  begin aluOp_o = AluXor;  srcSel_o = SrcImm; xDst = DstAlu; end
      OpcLw:    begin aluOp_o = AluAdd;  memOp_o = 1'b1; xDst = DstLoad; end
      OpcLwi: begin
        aluOp_o  = AluAdd;
        srcSel_o = SrcImm;
        memOp_o  = 1'b1;
        xDst     = DstLoad;
      end
      OpcSw:    begin aluOp_o = AluAdd; memOp_o = 1'b1; storeOp_o = 1'b1; end
      OpcSwi: begin
        aluOp_o   = AluAdd;
        srcSel_o  = SrcImm;
        memOp_o   = 1'b1;
        storeOp_o = 1'b1;
      end
      OpcBri, OpcBcci: begin
        srcSel_o   = SrcImm;  // Pass keeps A on the result for the test
        isBranch_o = 1'b1;
      end
      default: ;
    endcase
  end

  // Destination into W, nothing written for squashed slots
  always_ff @(posedge sysClk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      rDst   <= DstNone;
      rWrReg <= '0;
    end else if (cpuEnable_i) begin
      rDst   <= squash_i ? DstNone : xDst;
      rWrReg <= (squash_i || xDst == DstNone) ? '0 : rd_i;
    end
  end

  assign dstSel_o = rDst;
  assign wrReg_o  = rWrReg;

endmodule

// File: aexmCtrlPkg.sv
/* AEXM datapath control types
   Mux selects that the decoder hands to execute and writeback */
package aexmCtrlPkg;

  // ALU function in X
  typedef enum logic [2:0] {
    AluAdd  = 3'd0,
    AluRsub = 3'd1,  // B - A
    AluAnd  = 3'd2,
    AluOr   = 3'd3,
    AluXor  = 3'd4,
    AluPass = 3'd5   // Forwarded A straight through
  } aluOpE;

  // Operand B source
  typedef enum logic [1:0] {
    SrcReg = 2'd0,
    SrcImm = 2'd1
  } srcSelE;

  // Writeback source in W
  typedef enum logic [1:0] {
    DstAlu  = 2'd0,
    DstLoad = 2'd1,
    DstNone = 2'd2
  } dstSelE;

endpackage

// File: aexmEnable.sv
/* AEXM stall unit
   Global pipeline enable from both cache busy lines, cache enable gating */
`timescale 1ns/1ps

module aexmEnable (
  input  logic sysClk_i,
  input  logic rstN_i,
  input  logic icacheBusy_i,
  input  logic dcacheBusy_i,
  input  logic memOp_i,         // Load or store sitting in X
  output logic cpuEnable_o,
  output logic icacheEnable_o,
  output logic dcacheEnable_o
);

  logic rRun;  // Low for the first cycle out of reset

  always_ff @(posedge sysClk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      rRun <= 1'b0;
    end else begin
      rRun <= 1'b1;
    end
  end

  // Pipeline moves only when both caches can take the access
  assign cpuEnable_o = rRun & ~icacheBusy_i & ~dcacheBusy_i;

  // An access may only complete on an edge where the pipeline also moves,
  // otherwise returning data would overwrite the word a frozen stage holds
  assign icacheEnable_o = ~dcacheBusy_i;            // Fetch always wanted
  assign dcacheEnable_o = memOp_i & ~icacheBusy_i;  // Only for access in X

endmodule

// File: aexmIbuf.sv
/* AEXM instruction buffer
   Latches the fetched word into X and splits it into fields */
`timescale 1ns/1ps
`include "aexm_defs.svh"

module aexmIbuf
  import aexmIsaPkg::*;
(
  input  logic                sysClk_i,
  input  logic                rstN_i,
  input  logic                cpuEnable_i,
  input  logic                squash_i,
  input  logic [`AEXM_DW-1:0] icacheData_i,
  output opcodeE              opc_o,
  output regIdxT              rd_o,
  output regIdxT              ra_o,
  output regIdxT              rb_o,
  output logic [`AEXM_DW-1:0] simm_o,
  output regIdxT              dRa_o,        // D-stage read index A
  output regIdxT              dRb_o         // D-stage read index B
);

  localparam logic [`AEXM_DW-1:0] NopWord = 32'h8000_0000;  // or r0, r0, r0

  logic [`AEXM_DW-1:0] rIreg;  // Instruction now in X
  immT                 imm;

  always_ff @(posedge sysClk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      rIreg <= NopWord;
    end else if (cpuEnable_i) begin
      rIreg <= squash_i ? NopWord : icacheData_i;  // Killed slot becomes nop
    end
  end

  // X-stage fields
  assign opc_o = opcodeE'(rIreg[31:26]);
  assign rd_o  = rIreg[25:21];  // Also branch condition / store source
  assign ra_o  = rIreg[20:16];
  assign rb_o  = rIreg[15:11];
  assign imm   = rIreg[15:0];

  assign simm_o = {{(`AEXM_DW-16){imm[15]}}, imm};  // Sign extend

  // Straight off the cache so the register file can read on the same edge
  assign dRa_o = icacheData_i[20:16];
  assign dRb_o = icacheData_i[15:11];

endmodule

// File: aexmIsaPkg.sv
/* AEXM instruction set types
   Major opcodes, branch conditions and instruction field types */
package aexmIsaPkg;

  // Major opcode, instruction bits 31:26
  typedef enum logic [5:0] {
    OpcAdd   = 6'h00,  // rD = rA + rB
    OpcRsub  = 6'h01,  // rD = rB - rA
    OpcAddi  = 6'h08,
    OpcRsubi = 6'h09,
    OpcOr    = 6'h20,
    OpcAnd   = 6'h21,
    OpcXor   = 6'h22,
    OpcOri   = 6'h28,
    OpcAndi  = 6'h29,
    OpcXori  = 6'h2A,
    OpcBri   = 6'h2E,  // PC relative, always taken
    OpcBcci  = 6'h2F,  // Test on rA, condition in rD field
    OpcLw    = 6'h32,
    OpcSw    = 6'h36,
    OpcLwi   = 6'h3A,
    OpcSwi   = 6'h3E
  } opcodeE;

  // Branch condition, low bits of the rD field
  typedef enum logic [2:0] {
    CondEq = 3'd0,  // rA == 0
    CondNe = 3'd1   // rA != 0
  } branchCondE;

  typedef logic [4:0]  regIdxT;  // Register index field
  typedef logic [15:0] immT;     // Raw immediate field

endpackage

// File: aexmRegf.sv
/* AEXM register file
   31 writable registers, r0 reads zero, synchronous D-stage reads */
`timescale 1ns/1ps
`include "aexm_defs.svh"

module aexmRegf
  import aexmIsaPkg::*;
  import aexmCtrlPkg::*;
(
  input  logic                sysClk_i,
  input  logic                rstN_i,
  input  logic                cpuEnable_i,
  input  regIdxT              dRa_i,
  input  regIdxT              dRb_i,
  input  regIdxT              rd_i,         // X-stage store source
  input  regIdxT              wrReg_i,
  input  dstSelE              dstSel_i,
  input  logic [`AEXM_DW-1:0] result_i,
  input  logic [`AEXM_DW-1:0] loadData_i,
  output logic [`AEXM_DW-1:0] regA_o,
  output logic [`AEXM_DW-1:0] regB_o,
  output logic [`AEXM_DW-1:0] regD_o,
  output logic [`AEXM_DW-1:0] wbValue_o
);

  logic [`AEXM_DW-1:0] rf [`AEXM_NREG];  // Entry 0 never written
  logic                wrEn;

  assign wbValue_o = (dstSel_i == DstLoad) ? loadData_i : result_i;
  assign wrEn      = cpuEnable_i && (dstSel_i != DstNone) && (wrReg_i != '0);

  always_ff @(posedge sysClk_i) begin
    if (wrEn) begin
      rf[wrReg_i] <= wbValue_o;
    end
  end

  // Read with write-through so a W two slots ahead is not missed
  always_ff @(posedge sysClk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      regA_o <= '0;
      regB_o <= '0;
    end else if (cpuEnable_i) begin
      regA_o <= (dRa_i == '0) ? '0 :
                (wrEn && wrReg_i == dRa_i) ? wbValue_o : rf[dRa_i];
      regB_o <= (dRb_i == '0) ? '0 :
                (wrEn && wrReg_i == dRb_i) ? wbValue_o : rf[dRb_i];
    end
  end

  // Store data read in X, W value gets forwarded on top
  assign regD_o = (rd_i == '0) ? '0 : rf[rd_i];

endmodule

// File: aexmXecu.sv
/* AEXM execute unit
   Operand forwarding from W, ALU, data address and result register */
`timescale 1ns/1ps
`include "aexm_defs.svh"

module aexmXecu
  import aexmIsaPkg::*;
  import aexmCtrlPkg::*;
(
  input  logic                sysClk_i,
  input  logic                rstN_i,
  input  logic                cpuEnable_i,
  input  aluOpE               aluOp_i,
  input  srcSelE              srcSel_i,
  input  regIdxT              ra_i,
  input  regIdxT              rb_i,
  input  regIdxT              rd_i,
  input  logic [`AEXM_DW-1:0] simm_i,
  input  logic [`AEXM_DW-1:0] regA_i,
  input  logic [`AEXM_DW-1:0] regB_i,
  input  logic [`AEXM_DW-1:0] regD_i,
  input  regIdxT              wrReg_i,      // W destination, zero if none
  input  logic [`AEXM_DW-1:0] wbValue_i,
  output logic [`AEXM_DW-1:0] result_o,
  output logic [`AEXM_DW-1:0] rResult_o,
  output logic [`AEXM_DW-1:0] dataAddr_o,
  output logic [`AEXM_DW-1:0] storeData_o
);

  logic                fwdA;
  logic                fwdB;
  logic                fwdD;
  logic [`AEXM_DW-1:0] opA;
  logic [`AEXM_DW-1:0] opB;

  // r0 never matches since wrReg is zero for non-writing slots
  assign fwdA = (ra_i == wrReg_i) && (wrReg_i != '0);
  assign fwdB = (rb_i == wrReg_i) && (wrReg_i != '0);
  assign fwdD = (rd_i == wrReg_i) && (wrReg_i != '0);

  assign opA = fwdA ? wbValue_i : regA_i;
  assign opB = (srcSel_i == SrcImm) ? simm_i :
               fwdB ? wbValue_i : regB_i;

  always_comb begin
    case (aluOp_i)
      AluAdd:  result_o = opA + opB;
      AluRsub: result_o = opB - opA;
      AluAnd:  result_o = opA & opB;
      AluOr:   result_o = opA | opB;
      AluXor:  result_o = opA ^ opB;
      default: result_o = opA;  // Pass, branch test value
    endcase
  end

  assign dataAddr_o  = opA + opB;               // rA + rB or rA + imm
  assign storeData_o = fwdD ? wbValue_i : regD_i;

  always_ff @(posedge sysClk_i or negedge rstN_i) begin
    if (!rstN_i) begin
      rResult_o <= '0;
    end else if (cpuEnable_i) begin
      rResult_o <= result_o;  // Into W
    end
  end

endmodule

// File: aexm_defs.svh
/* AEXM core constants
   Datapath width, register count and reset vector */
`ifndef AEXM_DEFS_SVH
`define AEXM_DEFS_SVH

// Data and address width
`define AEXM_DW 32

// Register count including the hardwired r0
`define AEXM_NREG 32

// First fetch address once reset is released
`define AEXM_RESET_PC 32'h0000_0000

`endif

// File: run.sh
#!/usr/bin/env bash
# Build the AEXM core testbench with Verilator and run it
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f vlog.f --top-module tbAexmCore -Mdir obj_dir
./obj_dir/VtbAexmCore | tee sim.log

if grep -q "Finished with errors" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"

// File: tbAexmCore.sv
/* AEXM core testbench
   Cache models with random busy, ISA reference interpreter, in-order store checker */
`timescale 1ns/1ps
`include "aexm_defs.svh"

module tbAexmCore
  import aexmIsaPkg::*;
();

  localparam logic [31:0] FinishAddr = 32'h0000_03FC;  // Last store of every program
  localparam int          RunTimeout = 5000;           // Cycles per program run
  localparam int          MaxStores  = 64;

  logic        sysClk, rstN, icacheBusy, dcacheBusy, icacheEn, dcacheEn, dcacheWe;
  logic [31:0] icacheAddr, icacheDatai, dcacheAddr, dcacheDatao, dcacheDatai;

  logic [31:0] imem [256];       // Program, word indexed
  logic [31:0] dmem [256];
  logic [31:0] expAddr [MaxStores];
  logic [31:0] expData [MaxStores];
  int          expCount, stIdx, wrPos, errors, checks;
  logic        runDone, randBusy, timedOut, iDone, dLoad, b0, b1;
  logic [7:0]  iIdx, dIdx;
  logic [15:0] lfsr;
  string       testName;
  string       progName [2] = '{"aluFwd", "loadBranch"};

  aexmCore u_aexmCore (
    .sysClk_i(sysClk), .rstN_i(rstN),
    .icachePrecycleAddr_o(icacheAddr), .icachePrecycleEnable_o(icacheEn),
    .icacheDatai_i(icacheDatai), .icacheCacheBusy_i(icacheBusy),
    .dcachePrecycleAddr_o(dcacheAddr), .dcachePrecycleEnable_o(dcacheEn),
    .dcachePrecycleWe_o(dcacheWe), .dcacheDatao_o(dcacheDatao),
    .dcacheDatai_i(dcacheDatai), .dcacheCacheBusy_i(dcacheBusy)
  );

  initial begin
    sysClk = 1'b0;
    forever #2 sysClk = ~sysClk;  // 4 ns period
  end

  // Galois LFSR, one step per bit
  function automatic logic takeBit();
    logic lsb;
    lsb  = lfsr[0];
    lfsr = lfsr >> 1;
    if (lsb) begin
      lfsr = lfsr ^ 16'hB400;
    end
    return lsb;
  endfunction

  function automatic logic [31:0] memFill(logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h5A, 8'hC3};  // Never zero
  endfunction

  function automatic logic [31:0] encR(opcodeE opc, int rd, int ra, int rb);
    return {opc, rd[4:0], ra[4:0], rb[4:0], 11'd0};
  endfunction

  function automatic logic [31:0] encI(opcodeE opc, int rd, int ra, int imm);
    return {opc, rd[4:0], ra[4:0], imm[15:0]};
  endfunction

  task automatic emit(logic [31:0] word);
    imem[wrPos[7:0]] = word;
    wrPos++;
  endtask

  task automatic loadProgram(int p);
    for (int i = 0; i < 256; i++) begin
      imem[i] = encR(OpcOr, 0, 0, 0);  // Nop fill
    end
    wrPos = 0;
    if (p == 0) begin
      emit(encI(OpcAddi, 1, 0, 100));
      emit(encI(OpcAddi, 2, 1, -7));       // Back to back on r1
      emit(encR(OpcAdd, 3, 1, 2));
      emit(encI(OpcSwi, 3, 0, 'h100));     // Store data straight from W
      emit(encR(OpcRsub, 4, 3, 1));        // r1 - r3
      emit(encI(OpcRsubi, 5, 2, -1));
      emit(encR(OpcAnd, 6, 4, 5));
      emit(encI(OpcSwi, 4, 0, 'h104));
      emit(encI(OpcOri, 7, 6, 'h1234));
      emit(encR(OpcXor, 8, 7, 3));
      emit(encI(OpcXori, 9, 8, 'hAAAA));   // Negative immediate
      emit(encI(OpcAndi, 10, 9, 'h7FF0));
      emit(encI(OpcSwi, 10, 0, 'h108));
      emit(encI(OpcAddi, 0, 1, 5));        // Lost, r0 stays zero
      emit(encI(OpcSwi, 0, 0, 'h10C));
      emit(encI(OpcAddi, 11, 0, 'h200));
      emit(encI(OpcAddi, 12, 0, 8));
      emit(encR(OpcSw, 9, 11, 12));        // Register form address
      emit(encI(OpcSwi, 8, 12, 'h110));
    end else begin
      emit(encI(OpcLwi, 1, 0, 'h40));
      emit(encI(OpcAddi, 2, 1, 1));        // Load use
      emit(encI(OpcSwi, 2, 0, 'h300));
      emit(encI(OpcAddi, 3, 0, 'h80));
      emit(encR(OpcLw, 4, 3, 0));
      emit(encI(OpcSwi, 4, 3, 'h10));      // Stores the word just loaded
      emit(encI(OpcAddi, 5, 0, 3));        // Loop count
      emit(encI(OpcAddi, 6, 0, 0));
      emit(encI(OpcAddi, 7, 0, 0));
      emit(encI(OpcAddi, 6, 6, 7));        // Loop top, word 9
      emit(encI(OpcAddi, 7, 7, 4));
      emit(encR(OpcSw, 6, 7, 3));
      emit(encI(OpcAddi, 5, 5, -1));
      emit(encI(OpcBcci, 1, 5, -16));      // Ne, back to word 9
      emit(encI(OpcSwi, 5, 0, 'h3F0));
      emit(encI(OpcBcci, 0, 5, 12));       // Eq, taken
      emit(encI(OpcSwi, 1, 0, 'h3E0));     // Squashed
      emit(encI(OpcSwi, 2, 0, 'h3E4));     // Never reached
      emit(encI(OpcBcci, 1, 5, 8));        // Ne, not taken
      emit(encI(OpcSwi, 3, 0, 'h3E8));
      emit(encI(OpcBcci, 0, 1, 8));        // Eq on nonzero, not taken
      emit(encI(OpcBri, 0, 0, 12));
      emit(encI(OpcSwi, 4, 0, 'h3D0));     // Squashed
      emit(encI(OpcSwi, 4, 0, 'h3D4));     // Squashed
    end
    emit(encI(OpcSwi, 0, 0, FinishAddr[15:0]));
    emit(encI(OpcBri, 0, 0, 0));           // Park
  endtask

  // Architectural run of imem, no pipeline, records every store in order
  function automatic int runReference();
    logic [31:0] r [32];
    logic [31:0] m [256];
    logic [31:0] pc, insn, a, b, imm, val, addr;
    opcodeE      opc;
    logic [4:0]  rd;
    logic        wr, taken, halt;
    int          n;
    for (int i = 0; i < 32; i++) r[i] = '0;
    for (int i = 0; i < 256; i++) m[i] = memFill(i[7:0]);
    pc   = `AEXM_RESET_PC;
    n    = 0;
    halt = 1'b0;
    for (int step = 0; step < 2000 && !halt; step++) begin
      insn  = imem[pc[9:2]];
      opc   = opcodeE'(insn[31:26]);
      rd    = insn[25:21];
      a     = r[insn[20:16]];
      b     = r[insn[15:11]];
      imm   = {{16{insn[15]}}, insn[15:0]};
      wr    = 1'b1;
      taken = 1'b0;
      val   = '0;
      addr  = a + ((opc == OpcLw || opc == OpcSw) ? b : imm);
      case (opc)
        OpcAdd:   val = a + b;
        OpcRsub:  val = b - a;
        OpcAnd:   val = a & b;
        OpcOr:    val = a | b;
        OpcXor:   val = a ^ b;
        OpcAddi:  val = a + imm;
        OpcRsubi: val = imm - a;
        OpcAndi:  val = a & imm;
        OpcOri:   val = a | imm;
        OpcXori:  val = a ^ imm;
        OpcLw, OpcLwi: val = m[addr[9:2]];
        OpcSw, OpcSwi: begin
          wr = 1'b0;
          m[addr[9:2]] = r[rd];
          if (n < MaxStores) begin
            expAddr[n] = addr;
            expData[n] = r[rd];
          end
          n++;
        end
        OpcBri: begin
          wr    = 1'b0;
          taken = 1'b1;
        end
        OpcBcci: begin
          wr    = 1'b0;
          taken = (rd[2:0] == 3'd0) ? (a == '0) : (rd[2:0] == 3'd1) ? (a != '0) : 1'b0;
        end
        default: wr = 1'b0;
      endcase
      if (wr && rd != 5'd0) r[rd] = val;
      if (taken && imm == '0) halt = 1'b1;  // Branch to itself ends the program
      pc = taken ? pc + imm : pc + 32'd4;
    end
    return n;
  endfunction

  // Fetch port on the reset vector, data port idle
  task automatic checkResetState();
    checks++;
    if (icacheAddr !== `AEXM_RESET_PC) begin
      errors++;
      $display("** Error %s: reset fetch address, expected %h, actual %h",
               testName, `AEXM_RESET_PC, icacheAddr);
    end
    if (icacheEn !== 1'b1) begin
      errors++;
      $display("** Error %s: reset fetch enable, expected 1, actual %b", testName, icacheEn);
    end
    if (dcacheEn !== 1'b0) begin
      errors++;
      $display("** Error %s: reset data enable, expected 0, actual %b", testName, dcacheEn);
    end
    if (dcacheWe !== 1'b0) begin
      errors++;
      $display("** Error %s: reset write enable, expected 0, actual %b", testName, dcacheWe);
    end
  endtask

  // Ten reset cycles while the next program and its reference are prepared
  task automatic startRun(int p, logic busyOn);
    @(posedge sysClk);
    #1;
    rstN     = 1'b0;
    randBusy = 1'b0;
    testName = $sformatf("%s%s", progName[p], busyOn ? "Busy" : "Idle");
    loadProgram(p);
    for (int i = 0; i < 256; i++) begin
      dmem[i] = memFill(i[7:0]);
    end
    expCount = runReference();
    stIdx    = 0;
    runDone  = 1'b0;
    repeat (9) begin
      @(posedge sysClk);
      #1;
    end
    checkResetState();
    randBusy = busyOn;  // Busy lines start toggling while still in reset
    @(posedge sysClk);
    #1;
    rstN = 1'b1;
  endtask

  // Finish store seen or cycle budget used up
  task automatic waitFinish(output logic late);
    int n;
    n = 0;
    while (!runDone && n < RunTimeout) begin
      @(posedge sysClk);
      #1;
      n++;
    end
    late = !runDone;
  endtask

  initial begin
    lfsr        = 16'd19293;
    rstN        = 1'b0;
    icacheBusy  = 1'b0;
    dcacheBusy  = 1'b0;
    icacheDatai = '0;
    dcacheDatai = '0;
    randBusy    = 1'b0;
    runDone     = 1'b0;
    timedOut    = 1'b0;
    stIdx       = 0;
    expCount    = 0;
    errors      = 0;
    checks      = 0;
    testName    = "reset";
    for (int run = 0; run < 4 && !timedOut; run++) begin
      startRun(run % 2, run >= 2);  // Both programs idle, then both with busy
      waitFinish(timedOut);
      if (timedOut) begin
        errors++;
        $display("Timeout in %s, the finish store never arrived", testName);
      end else begin
        checks++;
        if (stIdx != expCount) begin
          errors++;
          $display("** Error %s: store count, expected %0d, actual %0d",
                   testName, expCount, stIdx);
        end
      end
    end
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

  // Cache models and store checker, sample at negedge, drive 1 ns after posedge
  always begin
    @(negedge sysClk);
    iDone = icacheEn && !icacheBusy;
    iIdx  = icacheAddr[9:2];
    dLoad = dcacheEn && !dcacheBusy && !dcacheWe;
    dIdx  = dcacheAddr[9:2];
    if (dcacheEn && dcacheWe && !dcacheBusy) begin
      checks++;
      if (stIdx >= expCount) begin
        errors++;
        $display("Extra store in %s at address %h", testName, dcacheAddr);
      end else begin
        if (dcacheAddr !== expAddr[stIdx]) begin
          errors++;
          $display("** Error %s: store %0d address, expected %h, actual %h",
                   testName, stIdx, expAddr[stIdx], dcacheAddr);
        end
        if (dcacheDatao !== expData[stIdx]) begin
          errors++;
          $display("** Error %s: store %0d data, expected %h, actual %h",
                   testName, stIdx, expData[stIdx], dcacheDatao);
        end
      end
      stIdx++;
      dmem[dIdx] = dcacheDatao;
      if (dcacheAddr == FinishAddr) runDone = 1'b1;
    end
    @(posedge sysClk);
    #1;
    if (iDone) icacheDatai = imem[iIdx];
    if (dLoad) dcacheDatai = dmem[dIdx];
    b0 = takeBit();
    b1 = takeBit();
    icacheBusy = randBusy & b0 & b1;  // About one cycle in four
    b0 = takeBit();
    b1 = takeBit();
    dcacheBusy = randBusy & b0 & b1;
  end

endmodule

// File: vlog.f
+incdir+.
aexmIsaPkg.sv
aexmCtrlPkg.sv
aexmEnable.sv
aexmIbuf.sv
aexmCtrl.sv
aexmRegf.sv
aexmXecu.sv
aexmBpcu.sv
aexmCore.sv
tbAexmCore.sv
